/* filelist.f */
+incdir+tb
rtl/test_ctrl_pkg.sv
rtl/packet_reader.sv
rtl/test_sequencer.sv
rtl/reply_writer.sv
rtl/data_generator.sv
rtl/test_ctrl_top.sv
tb/tb_test_ctrl.sv

/* rtl/data_generator.sv */
/*
 * Data generator for the send test
 * Emits PACKET_COUNT DATA packets of PAYLOAD_LEN counting bytes over
 * a valid/ready handshake, the count running on across packets
 */
module data_generator #(
    parameter logic [7:0]          PACKET_COUNT = 8'd2,
    parameter test_ctrl_pkg::len_t PAYLOAD_LEN  = 6'd5
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 start_i,
    output logic                 valid_o,
    output test_ctrl_pkg::byte_t data_o,
    input  logic                 ready_i,
    output logic                 done_o
);
    import test_ctrl_pkg::*;

    typedef enum logic {
        GEN_HEADER,
        GEN_PAYLOAD
    } gen_state_t;

    gen_state_t state_q;
    logic [7:0] pkt_q;
    len_t       byte_q;
    byte_t      data_q;
    logic       accept;

    assign accept = valid_o & ready_i;
    // Header or next counting byte
    assign data_o = (state_q == GEN_HEADER) ? {CMD_TEST_DATA, PAYLOAD_LEN} : data_q;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q <= GEN_HEADER;
            valid_o <= 1'b0;
            done_o  <= 1'b0;
            pkt_q   <= '0;
            byte_q  <= '0;
            data_q  <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                state_q <= GEN_HEADER;
                valid_o <= 1'b1;
                pkt_q   <= '0;
                byte_q  <= '0;
                data_q  <= '0;
            end else if (accept) begin
                case (state_q)
                    GEN_HEADER: begin
                        byte_q  <= '0;
                        state_q <= GEN_PAYLOAD;
                    end
                    default: begin
                        data_q <= data_q + 8'd1;
                        byte_q <= byte_q + 6'd1;
                        // End of packet, then maybe end of stream
                        if (byte_q == PAYLOAD_LEN - 6'd1) begin
                            if (pkt_q == PACKET_COUNT - 8'd1) begin
                                valid_o <= 1'b0;
                                done_o  <= 1'b1;
                            end else begin
                                pkt_q   <= pkt_q + 8'd1;
                                state_q <= GEN_HEADER;
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

/* rtl/packet_reader.sv */
/*
 * Packet reader
 * Pops the show-ahead input FIFO while the sequencer listens and
 * splits the byte stream into header and payload events
 */
module packet_reader (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 rd_enable_i,
    input  logic                 in_empty_i,
    input  test_ctrl_pkg::byte_t in_data_i,
    output logic                 in_rd_en_o,
    output logic                 hdr_valid_o,
    output test_ctrl_pkg::cmd_t  hdr_cmd_o,
    output test_ctrl_pkg::len_t  hdr_len_o,
    output logic                 pay_valid_o,
    output test_ctrl_pkg::cmd_t  pay_cmd_o,
    output test_ctrl_pkg::byte_t pay_data_o
);
    import test_ctrl_pkg::*;

    typedef enum logic {
        RD_HEADER,
        RD_PAYLOAD
    } rd_state_t;

    rd_state_t state_q;
    // Payload bytes still to come
    len_t remain_q;
    // Command of the packet being read
    cmd_t cmd_q;

    // Pop in the same cycle the byte is seen
    assign in_rd_en_o = rd_enable_i & ~in_empty_i;

    // Header fields straight off the FIFO data
    assign hdr_valid_o = in_rd_en_o && (state_q == RD_HEADER);
    assign hdr_cmd_o   = in_data_i[7:6];
    assign hdr_len_o   = in_data_i[5:0];

    // Payload byte tagged with its packet command
    assign pay_valid_o = in_rd_en_o && (state_q == RD_PAYLOAD);
    assign pay_cmd_o   = cmd_q;
    assign pay_data_o  = in_data_i;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q  <= RD_HEADER;
            remain_q <= '0;
            cmd_q    <= CMD_TEST_START;
        end else if (in_rd_en_o) begin
            case (state_q)
                RD_HEADER: begin
                    // Empty packet, next byte is a header again
                    if (hdr_len_o != 6'd0) begin
                        remain_q <= hdr_len_o;
                        cmd_q    <= hdr_cmd_o;
                        state_q  <= RD_PAYLOAD;
                    end
                end
                RD_PAYLOAD: begin
                    remain_q <= remain_q - 6'd1;
                    // Last payload byte
                    if (remain_q == 6'd1) begin
                        state_q <= RD_HEADER;
                    end
                end
                default: begin
                    state_q <= RD_HEADER;
                end
            endcase
        end
    end

endmodule

/* rtl/reply_writer.sv */
/*
 * Reply writer
 * Buffers one reply of up to four bytes and writes it to the output
 * FIFO, one registered write per cycle with space. When idle it
 * forwards the generator stream under the same space rule
 */
module reply_writer (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 reply_load_i,
    input  test_ctrl_pkg::byte_t reply_byte0_i,
    input  test_ctrl_pkg::byte_t reply_byte1_i,
    input  test_ctrl_pkg::byte_t reply_byte2_i,
    input  test_ctrl_pkg::byte_t reply_byte3_i,
    output logic                 reply_done_o,
    input  logic                 gen_valid_i,
    input  test_ctrl_pkg::byte_t gen_data_i,
    output logic                 gen_ready_o,
    input  logic                 out_full_i,
    input  logic                 out_afull_i,
    output logic                 out_wr_en_o,
    output test_ctrl_pkg::byte_t out_data_o
);
    import test_ctrl_pkg::*;

    byte_t      reply_q [4];
    logic [1:0] idx_q;
    // Index of the last reply byte, equals the header length
    logic [1:0] last_q;
    logic       busy_q;
    logic       space;

    // Almost-full leaves room for the registered write
    assign space = ~out_full_i & ~out_afull_i;
    // Stream only while no reply is pending
    assign gen_ready_o = space & ~busy_q;

    // Reply bytes, loaded together
    always_ff @(posedge clk) begin
        if (reply_load_i) begin
            reply_q[0] <= reply_byte0_i;
            reply_q[1] <= reply_byte1_i;
            reply_q[2] <= reply_byte2_i;
            reply_q[3] <= reply_byte3_i;
        end
    end

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            busy_q       <= 1'b0;
            idx_q        <= '0;
            last_q       <= '0;
            reply_done_o <= 1'b0;
            out_wr_en_o  <= 1'b0;
            out_data_o   <= '0;
        end else begin
            out_wr_en_o  <= 1'b0;
            reply_done_o <= 1'b0;
            if (reply_load_i) begin
                busy_q <= 1'b1;
                idx_q  <= '0;
                last_q <= reply_byte0_i[1:0];
            end else if (busy_q) begin
                // Hold the byte under back-pressure
                if (space) begin
                    out_wr_en_o <= 1'b1;
                    out_data_o  <= reply_q[idx_q];
                    idx_q       <= idx_q + 2'd1;
                    if (idx_q == last_q) begin
                        busy_q       <= 1'b0;
                        reply_done_o <= 1'b1;
                    end
                end
            end else if (gen_valid_i && gen_ready_o) begin
                // Generator pass-through
                out_wr_en_o <= 1'b1;
                out_data_o  <= gen_data_i;
            end
        end
    end

endmodule

/* rtl/test_ctrl_pkg.sv */
/*
 * Test protocol controller package
 * Byte, command and length types shared by the controller blocks,
 * plus the command, test number and error codes of the protocol
 */
package test_ctrl_pkg;

    // ========================================
    // Types
    // ========================================

    // One FIFO byte
    typedef logic [7:0] byte_t;

    // Header fields, command in the top bits
    typedef logic [1:0] cmd_t;
    // Payload length in the low bits
    typedef logic [5:0] len_t;

    // ========================================
    // Protocol codes
    // ========================================

    // Header commands
    localparam cmd_t CMD_TEST_START   = 2'd0;
    localparam cmd_t CMD_TEST_DATA    = 2'd1;
    localparam cmd_t CMD_TEST_STOP    = 2'd2;
    localparam cmd_t CMD_TEST_STOPPED = 2'd3;

    // Test numbers carried by a START payload
    localparam byte_t TEST_RECEIVE      = 8'd1;
    localparam byte_t TEST_SEND         = 8'd2;
    localparam byte_t TEST_RECEIVE_SEND = 8'd3;

    // Error codes, first byte after a STOPPED header
    localparam byte_t ERR_NONE             = 8'd0;
    localparam byte_t ERR_START_PAYLOAD    = 8'd1;
    localparam byte_t ERR_STOP_PAYLOAD     = 8'd2;
    localparam byte_t ERR_INVALID_CMD      = 8'd3;
    localparam byte_t ERR_INVALID_TEST_NUM = 8'd4;
    localparam byte_t ERR_TEST_DATA        = 8'd5;

endpackage

/* rtl/test_ctrl_top.sv */
/*
 * Test protocol controller top level
 * Input FIFO reader, test sequencer, reply writer and send-test
 * generator on one clock, with the send-test packet shape as parameters
 */
module test_ctrl_top #(
    parameter logic [7:0]          PACKET_COUNT = 8'd2,
    parameter test_ctrl_pkg::len_t PAYLOAD_LEN  = 6'd5
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 in_empty_i,
    input  test_ctrl_pkg::byte_t in_data_i,
    output logic                 in_rd_en_o,
    input  logic                 out_full_i,
    input  logic                 out_afull_i,
    output logic                 out_wr_en_o,
    output test_ctrl_pkg::byte_t out_data_o,
    output logic                 test_ok_o,
    output logic                 test_fail_o
);
    import test_ctrl_pkg::*;

    // Reader events
    logic  hdr_valid;
    cmd_t  hdr_cmd;
    len_t  hdr_len;
    logic  pay_valid;
    cmd_t  pay_cmd;
    byte_t pay_data;
    logic  rd_enable;

    // Reply path
    logic  reply_load;
    byte_t reply_byte0;
    byte_t reply_byte1;
    byte_t reply_byte2;
    byte_t reply_byte3;
    logic  reply_done;

    // Send-test stream
    logic  gen_start;
    logic  gen_done;
    logic  gen_valid;
    logic  gen_ready;
    byte_t gen_data;

    packet_reader packet_reader_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .rd_enable_i (rd_enable),
        .in_empty_i  (in_empty_i),
        .in_data_i   (in_data_i),
        .in_rd_en_o  (in_rd_en_o),
        .hdr_valid_o (hdr_valid),
        .hdr_cmd_o   (hdr_cmd),
        .hdr_len_o   (hdr_len),
        .pay_valid_o (pay_valid),
        .pay_cmd_o   (pay_cmd),
        .pay_data_o  (pay_data)
    );

    test_sequencer test_sequencer_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .hdr_valid_i   (hdr_valid),
        .hdr_cmd_i     (hdr_cmd),
        .hdr_len_i     (hdr_len),
        .pay_valid_i   (pay_valid),
        .pay_cmd_i     (pay_cmd),
        .pay_data_i    (pay_data),
        .rd_enable_o   (rd_enable),
        .reply_load_o  (reply_load),
        .reply_byte0_o (reply_byte0),
        .reply_byte1_o (reply_byte1),
        .reply_byte2_o (reply_byte2),
        .reply_byte3_o (reply_byte3),
        .reply_done_i  (reply_done),
        .gen_start_o   (gen_start),
        .gen_done_i    (gen_done),
        .test_ok_o     (test_ok_o),
        .test_fail_o   (test_fail_o)
    );

    reply_writer reply_writer_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .reply_load_i  (reply_load),
        .reply_byte0_i (reply_byte0),
        .reply_byte1_i (reply_byte1),
        .reply_byte2_i (reply_byte2),
        .reply_byte3_i (reply_byte3),
        .reply_done_o  (reply_done),
        .gen_valid_i   (gen_valid),
        .gen_data_i    (gen_data),
        .gen_ready_o   (gen_ready),
        .out_full_i    (out_full_i),
        .out_afull_i   (out_afull_i),
        .out_wr_en_o   (out_wr_en_o),
        .out_data_o    (out_data_o)
    );

    data_generator #(
        .PACKET_COUNT (PACKET_COUNT),
        .PAYLOAD_LEN  (PAYLOAD_LEN)
    ) data_generator_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (gen_start),
        .valid_o (gen_valid),
        .data_o  (gen_data),
        .ready_i (gen_ready),
        .done_o  (gen_done)
    );

endmodule

/* rtl/test_sequencer.sv */
/*
 * Test sequencer
 * Checks headers and payloads against the protocol, tracks the
 * expected data counter, starts the generator for the send test and
 * hands replies to the writer. Halts after any error until reset
 */
module test_sequencer (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 hdr_valid_i,
    input  test_ctrl_pkg::cmd_t  hdr_cmd_i,
    input  test_ctrl_pkg::len_t  hdr_len_i,
    input  logic                 pay_valid_i,
    input  test_ctrl_pkg::cmd_t  pay_cmd_i,
    input  test_ctrl_pkg::byte_t pay_data_i,
    output logic                 rd_enable_o,
    output logic                 reply_load_o,
    output test_ctrl_pkg::byte_t reply_byte0_o,
    output test_ctrl_pkg::byte_t reply_byte1_o,
    output test_ctrl_pkg::byte_t reply_byte2_o,
    output test_ctrl_pkg::byte_t reply_byte3_o,
    input  logic                 reply_done_i,
    output logic                 gen_start_o,
    input  logic                 gen_done_i,
    output logic                 test_ok_o,
    output logic                 test_fail_o
);
    import test_ctrl_pkg::*;

    typedef enum logic [1:0] {
        SEQ_HALTED,
        SEQ_READING,
        SEQ_REPLYING,
        SEQ_SENDING
    } seq_state_t;

    seq_state_t state_q;
    // Go to halted once the reply is out
    logic halt_after_q;
    byte_t test_num_q;
    // Next data byte the receive tests expect
    byte_t expected_q;

    // Only pop while reading, drops the cycle after a reply is queued
    assign rd_enable_o = (state_q == SEQ_READING);

    // ========================================
    // Reply helpers
    // ========================================

    task automatic load_reply(input byte_t b0, input byte_t b1, input byte_t b2,
                              input byte_t b3, input logic halt);
        reply_load_o  <= 1'b1;
        reply_byte0_o <= b0;
        reply_byte1_o <= b1;
        reply_byte2_o <= b2;
        reply_byte3_o <= b3;
        halt_after_q  <= halt;
        state_q       <= SEQ_REPLYING;
    endtask

    // STOPPED header with error code and diagnostics
    task automatic fail_reply(input len_t len, input byte_t code, input byte_t b2,
                              input byte_t b3);
        load_reply({CMD_TEST_STOPPED, len}, code, b2, b3, 1'b1);
        test_fail_o <= 1'b1;
    endtask

    // Stopped, no error
    task automatic ok_reply();
        load_reply({CMD_TEST_STOPPED, 6'd1}, ERR_NONE, 8'h00, 8'h00, 1'b0);
        test_ok_o <= 1'b1;
    endtask

    // ========================================
    // Test FSM
    // ========================================

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q       <= SEQ_READING;
            halt_after_q  <= 1'b0;
            test_num_q    <= '0;
            expected_q    <= '0;
            reply_load_o  <= 1'b0;
            reply_byte0_o <= '0;
            reply_byte1_o <= '0;
            reply_byte2_o <= '0;
            reply_byte3_o <= '0;
            gen_start_o   <= 1'b0;
            test_ok_o     <= 1'b0;
            test_fail_o   <= 1'b0;
        end else begin
            // Single-cycle pulses
            reply_load_o <= 1'b0;
            gen_start_o  <= 1'b0;
            case (state_q)
                SEQ_READING: begin
                    if (hdr_valid_i) begin
                        case (hdr_cmd_i)
                            CMD_TEST_START: begin
                                // New test, fresh status and counter
                                test_ok_o   <= 1'b0;
                                test_fail_o <= 1'b0;
                                expected_q  <= '0;
                                if (hdr_len_i != 6'd1) begin
                                    fail_reply(6'd1, ERR_START_PAYLOAD, 8'h00, 8'h00);
                                end
                            end
                            CMD_TEST_STOP: begin
                                if (hdr_len_i == 6'd0) begin
                                    ok_reply();
                                end else begin
                                    fail_reply(6'd1, ERR_STOP_PAYLOAD, 8'h00, 8'h00);
                                end
                            end
                            CMD_TEST_STOPPED: begin
                                // Only the controller sends this one
                                fail_reply(6'd1, ERR_INVALID_CMD, 8'h00, 8'h00);
                            end
                            default: begin
                                // DATA header, bytes checked as payload
                            end
                        endcase
                    end else if (pay_valid_i) begin
                        case (pay_cmd_i)
                            CMD_TEST_START: begin
                                test_num_q <= pay_data_i;
                                if (pay_data_i == TEST_SEND) begin
                                    gen_start_o <= 1'b1;
                                    state_q     <= SEQ_SENDING;
                                end else if (pay_data_i != TEST_RECEIVE &&
                                             pay_data_i != TEST_RECEIVE_SEND) begin
                                    fail_reply(6'd2, ERR_INVALID_TEST_NUM, pay_data_i, 8'h00);
                                end
                            end
                            CMD_TEST_DATA: begin
                                if (pay_data_i != expected_q) begin
                                    // Received byte, then expected byte
                                    fail_reply(6'd3, ERR_TEST_DATA, pay_data_i, expected_q);
                                end else begin
                                    expected_q <= expected_q + 8'd1;
                                    // Loop-back echoes each good byte
                                    if (test_num_q == TEST_RECEIVE_SEND) begin
                                        load_reply({CMD_TEST_DATA, 6'd1}, pay_data_i,
                                                   8'h00, 8'h00, 1'b0);
                                    end
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                SEQ_SENDING: begin
                    if (gen_done_i) begin
                        ok_reply();
                    end
                end
                SEQ_REPLYING: begin
                    if (reply_done_i) begin
                        state_q <= halt_after_q ? SEQ_HALTED : SEQ_READING;
                    end
                end
                default: begin
                    // Halted, wait for reset
                end
            endcase
        end
    end

endmodule

/* tb/tb_util.svh */
/*
 * Testbench utilities for the test protocol controller
 * Galois LFSR step, value compare and the protocol codes
 */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Header commands, top two bits of a header
localparam logic [1:0] CMD_START   = 2'd0;
localparam logic [1:0] CMD_DATA    = 2'd1;
localparam logic [1:0] CMD_STOP    = 2'd2;
localparam logic [1:0] CMD_STOPPED = 2'd3;

// Test numbers
localparam logic [7:0] TEST_RECEIVE      = 8'd1;
localparam logic [7:0] TEST_SEND         = 8'd2;
localparam logic [7:0] TEST_RECEIVE_SEND = 8'd3;

// Error codes after a STOPPED header
localparam logic [7:0] ERR_NONE             = 8'd0;
localparam logic [7:0] ERR_START_PAYLOAD    = 8'd1;
localparam logic [7:0] ERR_STOP_PAYLOAD     = 8'd2;
localparam logic [7:0] ERR_INVALID_CMD      = 8'd3;
localparam logic [7:0] ERR_INVALID_TEST_NUM = 8'd4;
localparam logic [7:0] ERR_TEST_DATA        = 8'd5;

// Right-shifting Galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        $display("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                 $time, name, actual, expected);
        abort_run();
    end
endtask

`endif

/* tb/tb_test_ctrl.sv */
/*
 * Testbench for the test protocol controller
 * Models the show-ahead input FIFO and the output FIFO, then runs a
 * table of packet streams with their expected replies and status
 */
module tb_test_ctrl;

    localparam int         PERIOD        = 4;
    localparam int         RESET_CYCLES  = 3;
    localparam int         SETTLE_CYCLES = 24;
    localparam logic [7:0] PACKET_COUNT  = 8'd3;
    localparam logic [5:0] PAYLOAD_LEN   = 6'd4;

    logic       clk;
    logic       reset_i;
    logic       in_empty_i;
    logic [7:0] in_data_i;
    logic       in_rd_en_o;
    logic       out_full_i;
    logic       out_afull_i;
    logic       out_wr_en_o;
    logic [7:0] out_data_o;
    logic       test_ok_o;
    logic       test_fail_o;

    // FIFO models
    logic [7:0]  in_q [$];
    logic [7:0]  cap_q [$];
    logic [31:0] lfsr_q;
    logic        rand_afull;
    bit          table_done;
    int          watchdog_cycles;

    // Stimulus and expected table, flat byte storage plus row descriptors
    logic [7:0] in_bytes [$];
    logic [7:0] exp_bytes [$];
    int         row_in_start [$];
    int         row_in_n [$];
    int         row_exp_start [$];
    int         row_exp_n [$];
    int         row_left [$];
    logic       row_ok [$];
    logic       row_fail [$];
    logic       row_rand [$];

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error");
    endtask

    `include "tb_util.svh"

    test_ctrl_top #(
        .PACKET_COUNT (PACKET_COUNT),
        .PAYLOAD_LEN  (PAYLOAD_LEN)
    ) test_ctrl_top_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_empty_i  (in_empty_i),
        .in_data_i   (in_data_i),
        .in_rd_en_o  (in_rd_en_o),
        .out_full_i  (out_full_i),
        .out_afull_i (out_afull_i),
        .out_wr_en_o (out_wr_en_o),
        .out_data_o  (out_data_o),
        .test_ok_o   (test_ok_o),
        .test_fail_o (test_fail_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Pops and output writes take effect at the rising edge
    always @(posedge clk) begin
        if (!reset_i) begin
            if (in_rd_en_o && in_q.size() == 0) begin
                $display("Input FIFO was popped while empty");
                abort_run();
            end else if (in_rd_en_o) begin
                in_q.delete(0);
            end
            if (out_wr_en_o) begin
                cap_q.push_back(out_data_o);
            end
        end
    end

    // ========================================
    // Input driving, falling edge only
    // ========================================

    // Show-ahead head of the input queue
    task automatic drive_fifo();
        in_empty_i = (in_q.size() == 0);
        in_data_i  = (in_q.size() == 0) ? 8'h00 : in_q[0];
    endtask

    task automatic next_cycle();
        @(negedge clk);
        // One LFSR step per almost-full bit
        if (rand_afull) begin
            lfsr_q      = lfsr_step(lfsr_q);
            out_afull_i = lfsr_q[0];
        end else begin
            out_afull_i = 1'b0;
        end
        drive_fifo();
    endtask

    function automatic logic [7:0] hdr(input logic [1:0] cmd, input logic [5:0] len);
        return {cmd, len};
    endfunction

    // ========================================
    // Table building
    // ========================================

    task automatic new_row(input logic ok, input logic fail, input logic rnd, input int left);
        row_in_start.push_back(in_bytes.size());
        row_exp_start.push_back(exp_bytes.size());
        row_ok.push_back(ok);
        row_fail.push_back(fail);
        row_rand.push_back(rnd);
        row_left.push_back(left);
    endtask

    task automatic add_in(input logic [7:0] b);
        in_bytes.push_back(b);
    endtask

    task automatic add_exp(input logic [7:0] b);
        exp_bytes.push_back(b);
    endtask

    // Counts and time budget of the last row
    task automatic end_row();
        int in_n;
        int exp_n;
        in_n  = in_bytes.size() - row_in_start[row_in_start.size() - 1];
        exp_n = exp_bytes.size() - row_exp_start[row_exp_start.size() - 1];
        row_in_n.push_back(in_n);
        row_exp_n.push_back(exp_n);
        watchdog_cycles += 2 * (8 * (in_n + exp_n) + 40 + RESET_CYCLES + SETTLE_CYCLES + 2);
    endtask

    task automatic build_table();
        int i;
        int p;
        int d;
        // Receive test, counting data with an empty packet in between
        new_row(1'b1, 1'b0, 1'b0, 0);
        add_in(hdr(CMD_START, 6'd1));
        add_in(TEST_RECEIVE);
        add_in(hdr(CMD_DATA, 6'd3));
        for (i = 0; i < 3; i++) add_in(i[7:0]);
        add_in(hdr(CMD_DATA, 6'd0));
        add_in(hdr(CMD_DATA, 6'd4));
        for (i = 3; i < 7; i++) add_in(i[7:0]);
        add_in(hdr(CMD_STOP, 6'd0));
        add_exp(hdr(CMD_STOPPED, 6'd1));
        add_exp(ERR_NONE);
        end_row();
        // Receive-and-send, every byte echoed, random almost-full
        new_row(1'b1, 1'b0, 1'b1, 0);
        add_in(hdr(CMD_START, 6'd1));
        add_in(TEST_RECEIVE_SEND);
        for (p = 0; p < 2; p++) begin
            add_in(hdr(CMD_DATA, 6'd2));
            add_in(8'(2 * p));
            add_in(8'(2 * p + 1));
        end
        add_in(hdr(CMD_STOP, 6'd0));
        for (i = 0; i < 4; i++) begin
            add_exp(hdr(CMD_DATA, 6'd1));
            add_exp(i[7:0]);
        end
        add_exp(hdr(CMD_STOPPED, 6'd1));
        add_exp(ERR_NONE);
        end_row();
        // Send test under back-pressure, count runs on across packets
        new_row(1'b1, 1'b0, 1'b1, 0);
        add_in(hdr(CMD_START, 6'd1));
        add_in(TEST_SEND);
        d = 0;
        for (p = 0; p < PACKET_COUNT; p++) begin
            add_exp(hdr(CMD_DATA, PAYLOAD_LEN));
            for (i = 0; i < PAYLOAD_LEN; i++) begin
                add_exp(d[7:0]);
                d++;
            end
        end
        add_exp(hdr(CMD_STOPPED, 6'd1));
        add_exp(ERR_NONE);
        end_row();
        // Wrong data byte 5 where 2 is due, last byte and STOP stay queued
        new_row(1'b0, 1'b1, 1'b0, 2);
        add_in(hdr(CMD_START, 6'd1));
        add_in(TEST_RECEIVE);
        add_in(hdr(CMD_DATA, 6'd4));
        add_in(8'd0);
        add_in(8'd1);
        add_in(8'd5);
        add_in(8'd3);
        add_in(hdr(CMD_STOP, 6'd0));
        add_exp(hdr(CMD_STOPPED, 6'd3));
        add_exp(ERR_TEST_DATA);
        add_exp(8'd5);
        add_exp(8'd2);
        end_row();
        // START with two payload bytes
        new_row(1'b0, 1'b1, 1'b0, 2);
        add_in(hdr(CMD_START, 6'd2));
        add_in(TEST_RECEIVE);
        add_in(8'd0);
        add_exp(hdr(CMD_STOPPED, 6'd1));
        add_exp(ERR_START_PAYLOAD);
        end_row();
        // STOP carrying a payload byte
        new_row(1'b0, 1'b1, 1'b0, 1);
        add_in(hdr(CMD_STOP, 6'd1));
        add_in(8'd0);
        add_exp(hdr(CMD_STOPPED, 6'd1));
        add_exp(ERR_STOP_PAYLOAD);
        end_row();
        // STOPPED sent to the controller
        new_row(1'b0, 1'b1, 1'b0, 1);
        add_in(hdr(CMD_STOPPED, 6'd0));
        add_in(hdr(CMD_STOP, 6'd0));
        add_exp(hdr(CMD_STOPPED, 6'd1));
        add_exp(ERR_INVALID_CMD);
        end_row();
        // Unknown test number 9
        new_row(1'b0, 1'b1, 1'b0, 1);
        add_in(hdr(CMD_START, 6'd1));
        add_in(8'd9);
        add_in(hdr(CMD_STOP, 6'd0));
        add_exp(hdr(CMD_STOPPED, 6'd2));
        add_exp(ERR_INVALID_TEST_NUM);
        add_exp(8'd9);
        end_row();
    endtask

    // ========================================
    // Row execution
    // ========================================

    task automatic run_row(input int r);
        int i;
        int cycles;
        int limit;
        next_cycle();
        reset_i    = 1'b1;
        rand_afull = row_rand[r];
        in_q.delete();
        cap_q.delete();
        repeat (RESET_CYCLES) next_cycle();
        // Release reset and fill the input FIFO in the same edge
        reset_i = 1'b0;
        for (i = 0; i < row_in_n[r]; i++) begin
            in_q.push_back(in_bytes[row_in_start[r] + i]);
        end
        drive_fifo();
        limit  = 8 * (row_in_n[r] + row_exp_n[r]) + 40;
        cycles = 0;
        while (cap_q.size() < row_exp_n[r] && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (cap_q.size() < row_exp_n[r]) begin
            $display("Row %0d stalled with %0d of %0d output bytes after %0d cycles",
                     r, cap_q.size(), row_exp_n[r], cycles);
            abort_run();
        end else begin
            // Extra time to catch stray writes or pops
            repeat (SETTLE_CYCLES) next_cycle();
            check_value("output byte count", cap_q.size(), row_exp_n[r]);
            for (i = 0; i < row_exp_n[r]; i++) begin
                check_value($sformatf("row %0d out_data_o[%0d]", r, i), cap_q[i],
                            exp_bytes[row_exp_start[r] + i]);
            end
            check_value("test_ok_o", test_ok_o, row_ok[r]);
            check_value("test_fail_o", test_fail_o, row_fail[r]);
            check_value("input bytes left", in_q.size(), row_left[r]);
        end
    endtask

    initial begin
        reset_i         = 1'b1;
        in_empty_i      = 1'b1;
        in_data_i       = 8'h00;
        out_full_i      = 1'b0;
        out_afull_i     = 1'b0;
        lfsr_q          = 32'hc791ec94;
        rand_afull      = 1'b0;
        watchdog_cycles = 0;
        build_table();
        table_done = 1'b1;
        for (int r = 0; r < row_in_n.size(); r++) begin
            run_row(r);
        end
        $display("** PASS **");
        $finish;
    end

    // Limit from the byte counts of the whole table
    initial begin
        wait (table_done);
        #(watchdog_cycles * PERIOD);
        $display("Watchdog expired before all table rows finished");
        abort_run();
    end

endmodule
